//--- design/fetchPkg.sv
`default_nettype none

package fetchPkg;

   // Opcodes that block an interrupt from slipping in behind them
   // IMM prefix
   localparam logic [5:0] opImm = 6'o54;
   // Return from subroutine
   localparam logic [5:0] opRtd = 6'o55;
   // Unconditional branches, register and immediate forms
   localparam logic [1:0][5:0] opBru = {6'o56, 6'o46};
   // Conditional branches, register and immediate forms
   localparam logic [1:0][5:0] opBcc = {6'o57, 6'o47};

   // Branch and link to the interrupt vector at 0x10
   // Link goes to r14 and ra selects the absolute linked form
   localparam logic [31:0] intWord = {6'o56, 5'h0e, 5'h0c, 16'h0010};

   // Raw instruction word split into its fields
   typedef struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [4:0]  rb;
      // Low 11 bits, upper immediate bits live in rb
      logic [10:0] alt;
   } instFields;

   // One registered instruction, 83 bits
   typedef struct packed {
      instFields   fields;
      // Signed immediate, already extended or prefixed
      logic [31:0] simm;
      // Word came from the interrupt injector
      logic        injected;
      // Operand B is the immediate
      logic        typeB;
      // Upper immediate half came from an IMM prefix
      logic        imm16Valid;
      logic [15:0] pad;
   } decodedInst;

   // Decoded word together with its operands
   typedef struct packed {
      decodedInst  inst;
      logic [31:0] operandA;
      logic [31:0] operandB;
   } issueBundle;

endpackage

`default_nettype wire

//--- design/pcUnit.sv
`timescale 1ns/100ps
`default_nettype none

module pcUnit #(
   parameter logic [31:0] resetAddr = 32'h0000_0000,
   parameter int          addrWidth = 32
) (
   input  logic                 gclk,
   input  logic                 grst,
   input  logic                 stepEn,
   input  logic                 injectNow,
   input  logic                 branchTaken,
   input  logic [addrWidth-1:0] branchTarget,
   output logic [addrWidth-1:0] iAddr
);

   // One instruction word per step
   localparam logic [addrWidth-1:0] wordStep = addrWidth'(4);

   logic [addrWidth-1:0] seqAddr;
   logic                 advance;

   // Sequential successor of the current fetch address
   assign seqAddr = iAddr + wordStep;

   // Injection holds the PC so the displaced word is fetched again
   assign advance = stepEn && !injectNow;

   always_ff @(posedge gclk) begin
      if (grst) begin
         iAddr <= resetAddr[addrWidth-1:0];
      end else if (branchTaken) begin
         // Redirect wins over a step, stall or not
         iAddr <= branchTarget;
      end else if (advance) begin
         iAddr <= seqAddr;
      end
   end

   // Fetch address stays on a word boundary
   // Relies on resetAddr and every branch target being aligned
   pcAligned: assert property (
      @(posedge gclk) disable iff (grst)
      iAddr[1:0] == 2'b00
   ) else $error("Fetch address %h is not word aligned", iAddr);

endmodule

`default_nettype wire

//--- design/instBuffer.sv
`timescale 1ns/100ps
`default_nettype none

module instBuffer (
   input  logic                 gclk,
   input  logic                 grst,
   input  logic                 stepEn,
   input  logic                 msrIe,
   input  logic                 intReq,
   input  logic [31:0]          iData,
   output logic                 injectNow,
   output fetchPkg::decodedInst decoded
);

   // Two stage debounce on the request level
   logic [1:0]          intSync;
   logic                intShot;
   // Pending interrupt waiting for a safe slot
   logic                intLatch;

   // Opcode class of the word currently held
   logic [5:0]          curOpc;
   logic                isImm;
   logic                isRtd;
   logic                isBru;
   logic                isBcc;
   logic                unsafeSlot;

   // Word and immediate to be captured on the next step
   fetchPkg::instFields nextFields;
   logic [15:0]         prefixLow;
   logic [15:0]         nextLow;
   logic [31:0]         nextSimm;

   assign curOpc = decoded.fields.opcode;
   assign isImm  = (curOpc == fetchPkg::opImm);
   assign isRtd  = (curOpc == fetchPkg::opRtd);
   assign isBru  = (curOpc == fetchPkg::opBru[0]) || (curOpc == fetchPkg::opBru[1]);
   assign isBcc  = (curOpc == fetchPkg::opBcc[0]) || (curOpc == fetchPkg::opBcc[1]);

   // Prefix pairs with its successor, returns and branches own a delay slot
   assign unsafeSlot = isImm || isRtd || isBru || isBcc;

   // Request level must be seen on both stages
   assign intShot = &intSync;

   always_ff @(posedge gclk) begin
      if (grst) begin
         intSync  <= '0;
         intLatch <= 1'b0;
      end else begin
         // Sampling runs on its own, stalls do not matter
         if (msrIe) begin
            intSync <= {intSync[0], intReq};
         end else begin
            intSync <= '0;
         end
         if (stepEn && injectNow) begin
            // Injection issued, request is served
            intLatch <= 1'b0;
         end else begin
            intLatch <= (intLatch || intShot) && msrIe;
         end
      end
   end

   // Replace the fetched word when the slot allows it
   assign injectNow = intLatch && !unsafeSlot;

   assign nextFields = injectNow ? fetchPkg::intWord : iData;

   // Low halves of the held prefix and the incoming word
   assign prefixLow = {decoded.fields.rb, decoded.fields.alt};
   assign nextLow   = {nextFields.rb, nextFields.alt};

   // Prefix supplies the upper half, else plain sign extension
   assign nextSimm = isImm ? {prefixLow, nextLow} : {{16{nextLow[15]}}, nextLow};

   always_ff @(posedge gclk) begin
      if (grst) begin
         decoded <= '0;
      end else if (stepEn) begin
         decoded.fields     <= nextFields;
         decoded.simm       <= nextSimm;
         decoded.injected   <= injectNow;
         // Opcode bit 3 picks the immediate form
         decoded.typeB      <= nextFields.opcode[3];
         decoded.imm16Valid <= isImm;
         decoded.pad        <= '0;
      end
   end

   // Injection never lands right behind a prefix, return or branch
   injSafeSlot: assert property (
      @(posedge gclk) disable iff (grst)
      stepEn && unsafeSlot |=> !decoded.injected
   ) else $error("Interrupt word injected behind opcode %o", $past(curOpc));

   // Disabling interrupts drops anything pending
   latchClearedByIe: assert property (
      @(posedge gclk) disable iff (grst)
      !msrIe |=> !intLatch
   ) else $error("Interrupt latch still set after interrupt enable went low");

endmodule

`default_nettype wire

//--- design/operandFetch.sv
`timescale 1ns/100ps
`default_nettype none

module operandFetch (
   input  logic                 gclk,
   input  logic                 grst,
   input  logic                 wbEn,
   input  logic [4:0]           wbAddr,
   input  logic [31:0]          wbData,
   input  fetchPkg::decodedInst decoded,
   output fetchPkg::issueBundle issue
);

   // General purpose registers, entry 0 is never written
   logic [31:0] regFile [32];

   logic [4:0]  raIdx;
   logic [4:0]  rbIdx;
   logic [31:0] regA;
   logic [31:0] regB;

   assign raIdx = decoded.fields.ra;
   assign rbIdx = decoded.fields.rb;

   // Write back lands on the edge
   // A same cycle read still sees the old contents
   always_ff @(posedge gclk) begin
      if (wbEn && (wbAddr != 5'd0)) begin
         regFile[wbAddr] <= wbData;
      end
   end

   // r0 is hardwired to zero
   assign regA = (raIdx == 5'd0) ? 32'd0 : regFile[raIdx];
   assign regB = (rbIdx == 5'd0) ? 32'd0 : regFile[rbIdx];

   always_comb begin
      issue.inst     = decoded;
      issue.operandA = regA;
      // Type B takes the built immediate instead of rb
      if (decoded.typeB) begin
         issue.operandB = decoded.simm;
      end else begin
         issue.operandB = regB;
      end
   end

   // r0 reads zero even after write backs aimed at it
   zeroReg: assert property (
      @(posedge gclk) disable iff (grst)
      raIdx == 5'd0 |-> issue.operandA == 32'd0
   ) else $error("Operand A nonzero for r0");

   // A written register shows its new value one cycle later
   wbVisible: assert property (
      @(posedge gclk) disable iff (grst)
      wbEn && (wbAddr != 5'd0)
         |=> (raIdx != $past(wbAddr)) || (issue.operandA == $past(wbData))
   ) else $error("Operand A misses the previous write back to r%0d", $past(wbAddr));

endmodule

`default_nettype wire

//--- design/fetchTop.sv
`timescale 1ns/100ps
`default_nettype none

module fetchTop #(
   parameter logic [31:0] resetAddr = 32'h0000_0000,
   parameter int          addrWidth = 32
) (
   input  logic                 gclk,
   input  logic                 grst,
   input  logic                 stepEn,
   input  logic [31:0]          iData,
   input  logic                 intReq,
   input  logic                 msrIe,
   input  logic                 branchTaken,
   input  logic [addrWidth-1:0] branchTarget,
   input  logic                 wbEn,
   input  logic [4:0]           wbAddr,
   input  logic [31:0]          wbData,
   output logic [addrWidth-1:0] iAddr,
   output fetchPkg::issueBundle issue
);

   // Registered instruction handed to the operand stage
   fetchPkg::decodedInst decoded;
   // Buffer swaps in the interrupt word, PC must hold
   logic                 injectNow;

   pcUnit #(
      .resetAddr (resetAddr),
      .addrWidth (addrWidth)
   ) pcUnit_inst (
      .gclk         (gclk),
      .grst         (grst),
      .stepEn       (stepEn),
      .injectNow    (injectNow),
      .branchTaken  (branchTaken),
      .branchTarget (branchTarget),
      .iAddr        (iAddr)
   );

   instBuffer instBuffer_inst (
      .gclk      (gclk),
      .grst      (grst),
      .stepEn    (stepEn),
      .msrIe     (msrIe),
      .intReq    (intReq),
      .iData     (iData),
      .injectNow (injectNow),
      .decoded   (decoded)
   );

   operandFetch operandFetch_inst (
      .gclk    (gclk),
      .grst    (grst),
      .wbEn    (wbEn),
      .wbAddr  (wbAddr),
      .wbData  (wbData),
      .decoded (decoded),
      .issue   (issue)
   );

endmodule

`default_nettype wire

//--- sim/tbFetchTop.sv
`timescale 1ns/100ps
`default_nettype none

module tbFetchTop;

   localparam logic [31:0] resetAddr  = 32'h0000_0100;
   localparam int          addrWidth  = 32;
   localparam int          stimCycles = 3000;
   // Stimulus plus reset, register load and drain
   localparam int          cycleLimit = 4000;

   logic                 gclk;
   logic                 grst;
   logic                 stepEn;
   logic [31:0]          iData = '0;
   logic                 intReq;
   logic                 msrIe;
   logic                 branchTaken;
   logic [31:0]          branchTarget;
   logic                 wbEn;
   logic [4:0]           wbAddr;
   logic [31:0]          wbData;
   logic [31:0]          iAddr;
   fetchPkg::issueBundle issue;

   int errorCount = 0;
   int cycleCount = 0;

   // Instruction memory contents, fixed for the run
   logic [31:0] memTable [64];
   // Reference copy of the register file
   logic [31:0] modelRegs [32];

   // State seen at the previous edge
   logic [31:0]         prevPc;
   logic [31:0]         prevTarget;
   logic                prevReset;
   logic                prevStep;
   logic                prevBranch;
   logic [1:0]          ieHist;
   // Word captured on the last step, and the one held before it
   fetchPkg::instFields stepWord;
   fetchPkg::instFields heldPrev;
   // Steps taken while a request waits
   int                  reqSteps;

   // Expected outputs
   logic [31:0]         expPc;
   fetchPkg::instFields expFields;
   logic [15:0]         lowNew;
   logic [15:0]         lowPrev;
   logic [31:0]         expSimm;
   logic [31:0]         expA;
   logic [31:0]         expB;
   logic                expTypeB;
   logic                expPrefixed;

   fetchTop #(
      .resetAddr (resetAddr),
      .addrWidth (addrWidth)
   ) fetchTop_inst (
      .gclk         (gclk),
      .grst         (grst),
      .stepEn       (stepEn),
      .iData        (iData),
      .intReq       (intReq),
      .msrIe        (msrIe),
      .branchTaken  (branchTaken),
      .branchTarget (branchTarget),
      .wbEn         (wbEn),
      .wbAddr       (wbAddr),
      .wbData       (wbData),
      .iAddr        (iAddr),
      .issue        (issue)
   );

   initial gclk = 1'b0;
   always #5 gclk = ~gclk;

   // Prefixes, returns and branches close the injection slot
   function automatic logic isUnsafe(input logic [5:0] opc);
      return (opc == fetchPkg::opImm) || (opc == fetchPkg::opRtd) ||
             (opc == fetchPkg::opBru[0]) || (opc == fetchPkg::opBru[1]) ||
             (opc == fetchPkg::opBcc[0]) || (opc == fetchPkg::opBcc[1]);
   endfunction

   // Upper and byte address bits folded in so aliased slots differ
   function automatic logic [31:0] memWord(input logic [31:0] addr);
      return memTable[addr[7:2]] ^ {6'd0, addr[1:0], addr[31:8]};
   endfunction

   // Word shows up one cycle after its address
   always @(posedge gclk) iData <= memWord(iAddr);

   task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                 input logic [31:0] actVal);
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, expVal, actVal);
      errorCount++;
   endtask

   task automatic reportFailure(input string msg);
      $display("error at %0t: %s", $time, msg);
      errorCount++;
   endtask

   // Reference model, updated on every edge
   always @(posedge gclk) begin
      prevPc     <= iAddr;
      prevTarget <= branchTarget;
      prevReset  <= grst;
      prevStep   <= stepEn;
      prevBranch <= branchTaken;
      if (wbEn && (wbAddr != 5'd0)) begin
         modelRegs[wbAddr] <= wbData;
      end
      if (grst) begin
         stepWord <= '0;
         heldPrev <= '0;
         ieHist   <= '0;
         reqSteps <= 0;
      end else begin
         ieHist <= {ieHist[0], msrIe};
         if (stepEn) begin
            stepWord <= iData;
            heldPrev <= expFields;
         end
         // Count steps only while the request is held and unserved
         if (!msrIe || !intReq || issue.inst.injected) begin
            reqSteps <= 0;
         end else if (stepEn) begin
            reqSteps <= reqSteps + 1;
         end
      end
   end

   always_comb begin
      // Branch beats a step, an injected step holds the PC
      if (prevReset) begin
         expPc = resetAddr;
      end else if (prevBranch) begin
         expPc = prevTarget;
      end else if (prevStep && !issue.inst.injected) begin
         expPc = prevPc + 32'd4;
      end else begin
         expPc = prevPc;
      end
      expFields = issue.inst.injected ? fetchPkg::intWord : stepWord;
      lowNew    = {expFields.rb, expFields.alt};
      lowPrev   = {heldPrev.rb, heldPrev.alt};
      if (heldPrev.opcode == fetchPkg::opImm) begin
         expSimm = {lowPrev, lowNew};
      end else begin
         expSimm = {{16{lowNew[15]}}, lowNew};
      end
      // Immediate form by opcode bit 3, prefix flag from the word held before
      expTypeB    = expFields.opcode[3];
      expPrefixed = (heldPrev.opcode == fetchPkg::opImm);
      expA = (expFields.ra == 5'd0) ? 32'd0 : modelRegs[expFields.ra];
      if (expFields.opcode[3]) begin
         expB = expSimm;
      end else begin
         expB = (expFields.rb == 5'd0) ? 32'd0 : modelRegs[expFields.rb];
      end
   end

   pcCheck: assert property (@(posedge gclk) disable iff (grst) iAddr == expPc)
      else reportMismatch("iAddr", $sampled(expPc), $sampled(iAddr));

   fieldsCheck: assert property (@(posedge gclk) disable iff (grst)
      issue.inst.fields == expFields)
      else reportMismatch("issue.inst.fields", $sampled(expFields), $sampled(issue.inst.fields));

   simmCheck: assert property (@(posedge gclk) disable iff (grst) issue.inst.simm == expSimm)
      else reportMismatch("issue.inst.simm", $sampled(expSimm), $sampled(issue.inst.simm));

   typeBCheck: assert property (@(posedge gclk) disable iff (grst)
      issue.inst.typeB == expTypeB)
      else reportMismatch("issue.inst.typeB", 32'($sampled(expTypeB)),
                          32'($sampled(issue.inst.typeB)));

   prefixCheck: assert property (@(posedge gclk) disable iff (grst)
      issue.inst.imm16Valid == expPrefixed)
      else reportMismatch("issue.inst.imm16Valid", 32'($sampled(expPrefixed)),
                          32'($sampled(issue.inst.imm16Valid)));

   operandACheck: assert property (@(posedge gclk) disable iff (grst) issue.operandA == expA)
      else reportMismatch("issue.operandA", $sampled(expA), $sampled(issue.operandA));

   operandBCheck: assert property (@(posedge gclk) disable iff (grst) issue.operandB == expB)
      else reportMismatch("issue.operandB", $sampled(expB), $sampled(issue.operandB));

   resetClean: assert property (@(posedge gclk) disable iff (grst)
      prevReset |-> !issue.inst.injected)
      else reportFailure("injected flag set right after reset");

   injectSlot: assert property (@(posedge gclk) disable iff (grst)
      prevStep && issue.inst.injected |-> !isUnsafe(heldPrev.opcode))
      else reportFailure("interrupt injected behind a prefix, return or branch");

   // Enable low two edges back leaves nothing to inject
   injectNeedsIe: assert property (@(posedge gclk) disable iff (grst)
      prevStep && issue.inst.injected |-> ieHist[1])
      else reportFailure("interrupt injected while interrupts were disabled");

   injectLatency: assert property (@(posedge gclk) disable iff (grst) reqSteps <= 12)
      else reportFailure("held interrupt request not injected within 12 steps");

   task automatic fillTable();
      int         kind;
      logic [5:0] opc;
      for (int i = 0; i < 64; i++) begin
         kind = $urandom % 20;
         if (kind < 3) begin
            opc = fetchPkg::opImm;
         end else if (kind < 4) begin
            opc = fetchPkg::opRtd;
         end else if (kind < 5) begin
            opc = fetchPkg::opBru[$urandom % 2];
         end else if (kind < 6) begin
            opc = fetchPkg::opBcc[$urandom % 2];
         end else begin
            // Plain word, type A or B by opcode bit 3
            opc = 6'($urandom);
            while (isUnsafe(opc)) begin
               opc = 6'($urandom);
            end
         end
         memTable[i] = {opc, 26'($urandom)};
      end
   endtask

   task automatic runPhases();
      int mode;
      int done;
      done = 0;
      while (done < stimCycles) begin
         mode = $urandom % 4;
         repeat (50) begin
            @(posedge gclk);
            stepEn       <= ($urandom % 4) != 0;
            branchTaken  <= ($urandom % 12) == 0;
            branchTarget <= $urandom & 32'hFFFF_FFFC;
            wbEn         <= ($urandom % 3) == 0;
            wbAddr       <= 5'($urandom);
            wbData       <= $urandom;
            case (mode)
               0: begin
                  msrIe  <= 1'b1;
                  intReq <= 1'b0;
               end
               1: begin
                  // Request held, injection expected
                  msrIe  <= 1'b1;
                  intReq <= 1'b1;
               end
               2: begin
                  msrIe  <= 1'b0;
                  intReq <= 1'($urandom);
               end
               default: begin
                  msrIe  <= ($urandom % 8) != 0;
                  intReq <= 1'($urandom);
               end
            endcase
         end
         done += 50;
      end
   endtask

   initial begin
      void'($urandom(43680));
      grst         = 1'b1;
      stepEn       = 1'b0;
      intReq       = 1'b0;
      msrIe        = 1'b0;
      branchTaken  = 1'b0;
      branchTarget = '0;
      wbEn         = 1'b0;
      wbAddr       = '0;
      wbData       = '0;
      fillTable();
      repeat (8) @(posedge gclk);
      grst <= 1'b0;
      // Load r1..r31 while the buffer still holds the reset word
      for (int r = 1; r < 32; r++) begin
         @(posedge gclk);
         wbEn   <= 1'b1;
         wbAddr <= 5'(r);
         wbData <= $urandom;
      end
      @(posedge gclk);
      wbEn <= 1'b0;
      runPhases();
      @(posedge gclk);
      stepEn      <= 1'b0;
      branchTaken <= 1'b0;
      wbEn        <= 1'b0;
      repeat (2) @(posedge gclk);
      $display("Run finished after %0d cycles with %0d errors", cycleCount, errorCount);
      if (errorCount == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Hard stop in case the stimulus never finishes
   always @(posedge gclk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         $display("Run stopped at the %0d cycle limit with %0d errors", cycleLimit, errorCount);
         $display("TEST FAILED");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- filelist.f
design/fetchPkg.sv
design/pcUnit.sv
design/instBuffer.sv
design/operandFetch.sv
design/fetchTop.sv
sim/tbFetchTop.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
   --top-module tbFetchTop --Mdir obj_dir -o simFetch \
   || { echo "Verilator build failed"; exit 1; }
./obj_dir/simFetch > sim.log 2>&1
cat sim.log
grep -qx "TEST PASSED" sim.log \
   && echo "Simulation run succeeded" \
   || { echo "Simulation run failed, see sim.log"; exit 1; }
